// File: include/rv_opcodes.svh
`ifndef RV_OPCODES_SVH
`define RV_OPCODES_SVH

// Major opcodes handled by the core.
`define OPC_OP          7'b0110011
`define OPC_OP_IMM      7'b0010011

// funct3 codes of the integer ALU group.
`define F3_ADD_SUB      3'b000
`define F3_SLL          3'b001
`define F3_SLT          3'b010
`define F3_SLTU         3'b011
`define F3_XOR          3'b100
`define F3_SRL_SRA      3'b101
`define F3_OR           3'b110
`define F3_AND          3'b111

// funct7 selects sub and sra through this bit.
`define F7_ALT_BIT      5
`define F7_ALT          7'b0100000
`define F7_BASE         7'b0000000

`endif

// File: rtl/rv_pkg.sv
package rv_pkg;

    // ----------------------------------------------------------------------
    // Word sizes.
    // ----------------------------------------------------------------------
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int pc_step    = 4;

    // ----------------------------------------------------------------------
    // ALU operations.
    // ----------------------------------------------------------------------
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    // ----------------------------------------------------------------------
    // Stage payloads.
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic [xlen-1:0]       instr;
        logic [xlen-1:0]       pc;
    } fetch_t;

    typedef struct packed {
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [xlen-1:0]       rs1_val;   // Value read in decode.
        logic [xlen-1:0]       rs2_val;
        logic [xlen-1:0]       imm;       // Sign-extended I immediate.
        logic                  use_imm;
        alu_op_t               alu_op;
        logic [reg_addr_w-1:0] rd;
        logic                  we;
    } decode_t;

    typedef struct packed {
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       result;
        logic                  we;
    } exec_t;

    typedef struct packed {
        logic                  valid;
        logic                  write;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       data;
    } retire_t;

endpackage

// File: rtl/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     valid_in,
    input  payload_t data_in,
    output logic     valid_out,
    output payload_t data_out
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_out <= 1'b0;
        end else begin
            valid_out <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        data_out <= data_in;    // Payload moves every cycle.
    end

    // Upstream stages must hand over fully defined payloads.
    a_known_data: assert property (@(posedge clk) disable iff (!rst_n)
        valid_out |-> !$isunknown(data_out));

endmodule

// File: rtl/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage
    import rv_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  logic [31:0]     instruction,
    input  logic            instr_valid,
    output logic            valid,
    output fetch_t          fetched,
    output logic [31:0]     pc_out
);

    // ----------------------------------------------------------------------
    // Program counter and valid strobe.
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid  <= 1'b0;
            pc_out <= '0;
        end else begin
            valid <= instr_valid;
            if (instr_valid) begin
                pc_out <= pc_out + xlen'(pc_step);
            end
        end
    end

    // Fetch register, loaded only on an accepted word.
    always_ff @(posedge clk) begin
        if (instr_valid) begin
            fetched.instr <= instruction;
            fetched.pc    <= pc_out;
        end
    end

endmodule

// File: rtl/reg_bank.sv
`timescale 1ns/1ps

module reg_bank
    import rv_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [reg_addr_w-1:0] raddr_a,
    input  logic [reg_addr_w-1:0] raddr_b,
    input  logic                  we,
    input  logic [reg_addr_w-1:0] waddr,
    input  logic [xlen-1:0]       wdata,
    output logic [xlen-1:0]       rdata_a,
    output logic [xlen-1:0]       rdata_b
);

    localparam int num_regs = 2 ** reg_addr_w;

    logic [xlen-1:0] regs [num_regs];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // Read ports.
    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

    // Writeback never requests a write to x0.
    a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
        we |-> waddr != '0);

endmodule

// File: rtl/decode_stage.sv
`timescale 1ns/1ps
`include "rv_opcodes.svh"

module decode_stage
    import rv_pkg::*;
(
    input  logic                  valid_in,
    input  fetch_t                fetched,
    input  logic [xlen-1:0]       rdata_a,
    input  logic [xlen-1:0]       rdata_b,
    output logic [reg_addr_w-1:0] raddr_a,
    output logic [reg_addr_w-1:0] raddr_b,
    output logic                  valid_out,
    output decode_t               decoded
);

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       imm_i;

    // Maps funct3 plus the alternate bit onto an ALU operation.
    function automatic alu_op_t sel_op(input logic [2:0] f3, input logic alt);
        alu_op_t op;
        case (f3)
            `F3_ADD_SUB: op = alt ? alu_sub : alu_add;
            `F3_SLL:     op = alu_sll;
            `F3_SLT:     op = alu_slt;
            `F3_SLTU:    op = alu_sltu;
            `F3_XOR:     op = alu_xor;
            `F3_SRL_SRA: op = alt ? alu_sra : alu_srl;
            `F3_OR:      op = alu_or;
            default:     op = alu_and;
        endcase
        return op;
    endfunction

    // ----------------------------------------------------------------------
    // Field extraction.
    // ----------------------------------------------------------------------
    assign opcode  = fetched.instr[6:0];
    assign rd      = fetched.instr[11:7];
    assign funct3  = fetched.instr[14:12];
    assign raddr_a = fetched.instr[19:15];
    assign raddr_b = fetched.instr[24:20];
    assign funct7  = fetched.instr[31:25];
    assign imm_i   = {{(xlen-12){fetched.instr[31]}}, fetched.instr[31:20]};

    assign valid_out = valid_in;

    always_comb begin
        decoded.rs1     = raddr_a;
        decoded.rs2     = raddr_b;
        decoded.rs1_val = rdata_a;
        decoded.rs2_val = rdata_b;
        decoded.imm     = imm_i;
        decoded.rd      = rd;
        decoded.use_imm = 1'b0;
        decoded.alu_op  = alu_add;
        decoded.we      = 1'b0;     // Unknown opcodes write nothing.
        case (opcode)
            `OPC_OP: begin
                decoded.alu_op = sel_op(funct3, funct7[`F7_ALT_BIT]);
                decoded.we     = 1'b1;
            end
            `OPC_OP_IMM: begin
                // Only srai looks at the upper immediate bits.
                decoded.alu_op  = sel_op(funct3,
                    (funct3 == `F3_SRL_SRA) && funct7[`F7_ALT_BIT]);
                decoded.use_imm = 1'b1;
                decoded.we      = 1'b1;
            end
            default: begin
                decoded.we = 1'b0;
            end
        endcase
    end

endmodule

// File: rtl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage
    import rv_pkg::*;
(
    input  logic    valid_in,
    input  decode_t decoded,
    input  exec_t   ex_fwd,
    input  exec_t   wb_fwd,
    output logic    valid_out,
    output exec_t   result
);

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [4:0]      shamt;

    // Youngest matching write wins over the value read in decode.
    function automatic logic [xlen-1:0] pick(input logic [reg_addr_w-1:0] src,
                                             input logic [xlen-1:0] rf_val,
                                             input exec_t ex, input exec_t wb);
        if (ex.we && ex.rd != '0 && ex.rd == src) begin
            return ex.result;
        end else if (wb.we && wb.rd != '0 && wb.rd == src) begin
            return wb.result;
        end
        return rf_val;
    endfunction

    assign op_a  = pick(decoded.rs1, decoded.rs1_val, ex_fwd, wb_fwd);
    assign op_b  = decoded.use_imm ? decoded.imm :
                   pick(decoded.rs2, decoded.rs2_val, ex_fwd, wb_fwd);
    assign shamt = op_b[4:0];

    assign valid_out = valid_in;
    assign result.rd = decoded.rd;
    assign result.we = valid_in && decoded.we;  // Bubbles never forward.

    // ----------------------------------------------------------------------
    // ALU.
    // ----------------------------------------------------------------------
    always_comb begin
        case (decoded.alu_op)
            alu_add:  result.result = op_a + op_b;
            alu_sub:  result.result = op_a - op_b;
            alu_sll:  result.result = op_a << shamt;
            alu_slt:  result.result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            alu_sltu: result.result = {{(xlen-1){1'b0}}, op_a < op_b};
            alu_xor:  result.result = op_a ^ op_b;
            alu_srl:  result.result = op_a >> shamt;
            alu_sra:  result.result = $signed(op_a) >>> shamt;
            alu_or:   result.result = op_a | op_b;
            alu_and:  result.result = op_a & op_b;
            default:  result.result = '0;
        endcase
    end

    always_comb begin
        if (valid_in) begin
            a_legal_op: assert (decoded.alu_op inside {alu_add, alu_sub, alu_sll,
                alu_slt, alu_sltu, alu_xor, alu_srl, alu_sra, alu_or, alu_and})
                else $error("illegal alu_op %0d", decoded.alu_op);
        end
    end

endmodule

// File: rtl/writeback_stage.sv
`timescale 1ns/1ps

module writeback_stage
    import rv_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  valid_in,
    input  exec_t                 result,
    output logic                  we,
    output logic [reg_addr_w-1:0] waddr,
    output logic [xlen-1:0]       wdata,
    output exec_t                 wb_fwd,
    output retire_t               retire,
    output logic [7:0]            led
);

    logic commit;

    assign commit = valid_in && result.we && (result.rd != '0);
    assign we     = commit;
    assign waddr  = result.rd;
    assign wdata  = result.result;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_fwd <= '0;
            retire <= '0;
            led    <= '0;
        end else begin
            retire.valid <= valid_in;
            retire.write <= commit;
            retire.rd    <= result.rd;
            retire.data  <= result.result;
            if (commit) begin
                wb_fwd <= result;   // Last committed write.
            end
            if (commit && result.rd == reg_addr_w'(1)) begin
                led <= result.result[7:0];
            end
        end
    end

endmodule

// File: rtl/cpu.sv
`timescale 1ns/1ps

module cpu
    import rv_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] instruction,
    input  logic        instr_valid,
    output logic [7:0]  led,
    output logic [31:0] pc_out,
    output retire_t     retire
);

    logic                  f_valid;
    fetch_t                f_data;
    logic                  d_valid, dx_valid;
    decode_t               d_data, dx_data;
    logic                  x_valid, xw_valid;
    exec_t                 x_data, xw_data;
    exec_t                 wb_fwd;
    logic [reg_addr_w-1:0] raddr_a, raddr_b, waddr;
    logic [xlen-1:0]       rdata_a, rdata_b, wdata;
    logic                  we;

    fetch_stage fetch_inst (.clk(clk), .rst_n(rst_n),
                            .instruction(instruction), .instr_valid(instr_valid),
                            .valid(f_valid), .fetched(f_data), .pc_out(pc_out));

    decode_stage decode_inst (.valid_in(f_valid), .fetched(f_data),
                              .rdata_a(rdata_a), .rdata_b(rdata_b),
                              .raddr_a(raddr_a), .raddr_b(raddr_b),
                              .valid_out(d_valid), .decoded(d_data));

    reg_bank reg_bank_inst (.clk(clk), .rst_n(rst_n),
                            .raddr_a(raddr_a), .raddr_b(raddr_b),
                            .we(we), .waddr(waddr), .wdata(wdata),
                            .rdata_a(rdata_a), .rdata_b(rdata_b));

    // Decode to execute.
    pipe_reg #(.payload_t(decode_t)) dx_reg (.clk(clk), .rst_n(rst_n),
                                             .valid_in(d_valid), .data_in(d_data),
                                             .valid_out(dx_valid), .data_out(dx_data));

    execute_stage execute_inst (.valid_in(dx_valid), .decoded(dx_data),
                                .ex_fwd(xw_data), .wb_fwd(wb_fwd),
                                .valid_out(x_valid), .result(x_data));

    // Execute to writeback.
    pipe_reg #(.payload_t(exec_t)) xw_reg (.clk(clk), .rst_n(rst_n),
                                           .valid_in(x_valid), .data_in(x_data),
                                           .valid_out(xw_valid), .data_out(xw_data));

    writeback_stage writeback_inst (.clk(clk), .rst_n(rst_n),
                                    .valid_in(xw_valid), .result(xw_data),
                                    .we(we), .waddr(waddr), .wdata(wdata),
                                    .wb_fwd(wb_fwd), .retire(retire), .led(led));

endmodule

// File: bench/cpu_tb.sv
`timescale 1ns/1ps
`include "rv_opcodes.svh"

module cpu_tb
    import rv_pkg::*;
();

    localparam int         clk_period   = 20;
    localparam int         reset_cycles = 3;
    localparam int         num_random   = 300;
    localparam int         max_slots    = 80 + 2 * num_random;  // Directed plus random with gaps.
    localparam logic [6:0] opc_illegal  = 7'b0000011;

    logic        clk;
    logic        rst_n;
    logic [31:0] instruction;
    logic        instr_valid;
    logic [7:0]  led;
    logic [31:0] pc_out;
    retire_t     retire;

    logic [31:0] ref_regs [32];
    retire_t     exp_q [$];
    retire_t     exp_retire;
    logic [31:0] exp_pc;
    logic [7:0]  exp_led;
    int          error_count;
    int          check_count;
    int          write_count;
    integer      seed = 32'h31c5;

    cpu cpu_inst (.clk(clk), .rst_n(rst_n), .instruction(instruction),
                  .instr_valid(instr_valid), .led(led), .pc_out(pc_out), .retire(retire));

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, `OPC_OP_IMM};
    endfunction

    // RV32I meaning of one word, applied to the reference registers in program order.
    function automatic retire_t apply_instr(input logic [31:0] w);
        retire_t     r;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [2:0]  f3;
        logic        is_op;
        logic        alt;
        r     = '0;
        f3    = w[14:12];
        is_op = (w[6:0] == `OPC_OP);
        a     = ref_regs[w[19:15]];
        b     = is_op ? ref_regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
        alt   = w[30] && (is_op || f3 == `F3_SRL_SRA);   // addi has no sub form.
        case (f3)
            `F3_ADD_SUB: res = alt ? a - b : a + b;
            `F3_SLL:     res = a << b[4:0];
            `F3_SLT:     res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            `F3_SLTU:    res = (a < b) ? 32'd1 : 32'd0;
            `F3_XOR:     res = a ^ b;
            `F3_SRL_SRA: res = alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            `F3_OR:      res = a | b;
            default:     res = a & b;
        endcase
        r.valid = 1'b1;
        r.rd    = w[11:7];
        r.data  = res;
        r.write = (is_op || w[6:0] == `OPC_OP_IMM) && w[11:7] != 5'd0;
        if (r.write) begin
            ref_regs[w[11:7]] = res;
        end
        return r;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        error_count++;
        $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, expected, actual);
    endtask

    task automatic issue(input logic [31:0] w);
        @(posedge clk);
        instruction <= w;
        instr_valid <= 1'b1;
    endtask

    // The word left on the bus would write x1 if it were taken.
    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            instruction <= enc_r(`F7_BASE, 5'd2, 5'd1, `F3_ADD_SUB, 5'd1);
            instr_valid <= 1'b0;
        end
    endtask

    task automatic issue_random();
        logic [31:0] r;
        logic [11:0] imm;
        logic [6:0]  f7;
        r   = $random(seed);
        imm = r[23:12];
        f7  = (r[28] && (r[11:9] == `F3_ADD_SUB || r[11:9] == `F3_SRL_SRA)) ? `F7_ALT : `F7_BASE;
        if (r[11:9] == `F3_SLL || r[11:9] == `F3_SRL_SRA) begin
            imm[11:5] = (r[11:9] == `F3_SRL_SRA && r[28]) ? `F7_ALT : `F7_BASE;
        end
        if (r[31:29] == 3'b000) begin
            idle(1);
        end
        if (r[27:24] < 4'd7) begin
            issue(enc_r(f7, {2'b00, r[8:6]}, {2'b00, r[5:3]}, r[11:9], {2'b00, r[2:0]}));
        end else if (r[27:24] < 4'd14) begin
            issue(enc_i(imm, {2'b00, r[5:3]}, r[11:9], {2'b00, r[2:0]}));
        end else begin
            issue({imm, 2'b00, r[5:3], r[11:9], 2'b00, r[2:0], opc_illegal});
        end
    endtask

    // ----------------------------------------------------------------------
    // Reference model, retires each slot three edges after acceptance.
    // ----------------------------------------------------------------------
    always @(posedge clk) begin
        retire_t entry;
        entry = '0;
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                ref_regs[i] = '0;
            end
            exp_q.delete();
            repeat (3) begin
                exp_q.push_back(entry);
            end
            exp_retire = '0;
            exp_pc     = '0;
            exp_led    = '0;
        end else begin
            if (instr_valid) begin
                entry  = apply_instr(instruction);
                exp_pc = exp_pc + 32'(pc_step);
            end
            exp_q.push_back(entry);
            exp_retire = exp_q.pop_front();
            if (exp_retire.write && exp_retire.rd == 5'd1) begin
                exp_led = exp_retire.data[7:0];
            end
        end
    end

    // Outputs are compared half a cycle after each edge.
    always @(negedge clk) begin
        if (rst_n) begin
            check_count++;
            assert (retire.valid == exp_retire.valid)
                else report_mismatch("retire.valid", 32'(exp_retire.valid), 32'(retire.valid));
            assert (retire.write == exp_retire.write)
                else report_mismatch("retire.write", 32'(exp_retire.write), 32'(retire.write));
            if (exp_retire.valid) begin
                assert (retire.rd == exp_retire.rd)
                    else report_mismatch("retire.rd", 32'(exp_retire.rd), 32'(retire.rd));
            end
            if (exp_retire.write) begin
                write_count++;
                assert (retire.data == exp_retire.data)
                    else report_mismatch("retire.data", exp_retire.data, retire.data);
            end
            assert (led == exp_led) else report_mismatch("led", 32'(exp_led), 32'(led));
            assert (pc_out == exp_pc) else report_mismatch("pc_out", exp_pc, pc_out);
        end
    end

    initial begin
        #((max_slots + 20) * clk_period);
        $display("Watchdog expired: the stimulus did not finish within %0d cycles",
                 max_slots + 20);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        rst_n       = 1'b0;
        instruction = '0;
        instr_valid = 1'b0;
        error_count = 0;
        check_count = 0;
        write_count = 0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;

        // ------------------------------------------------------------------
        // Operands, then every R-type and I-type operation.
        // ------------------------------------------------------------------
        issue(enc_i(12'hffb, 5'd0, `F3_ADD_SUB, 5'd1));     // x1 = -5.
        issue(enc_i(12'h007, 5'd0, `F3_ADD_SUB, 5'd2));
        issue(enc_i(12'h800, 5'd0, `F3_ADD_SUB, 5'd3));     // Most negative immediate.
        issue(enc_i(12'h7ff, 5'd0, `F3_ADD_SUB, 5'd4));
        for (int f = 0; f < 8; f++) begin
            issue(enc_r(`F7_BASE, 5'd2, 5'd1, 3'(f), 5'd5));
            issue(enc_r(`F7_BASE, 5'd1, 5'd3, 3'(f), 5'd6));
        end
        issue(enc_r(`F7_ALT, 5'd2, 5'd1, `F3_ADD_SUB, 5'd7));
        issue(enc_r(`F7_ALT, 5'd2, 5'd1, `F3_SRL_SRA, 5'd7));
        for (int f = 0; f < 8; f++) begin
            issue(enc_i((f == 1 || f == 5) ? 12'h003 : 12'hff0, 5'd1, 3'(f), 5'd6));
        end
        issue(enc_i({`F7_ALT, 5'd2}, 5'd3, `F3_SRL_SRA, 5'd7));

        // Dependencies at distances 1, 2 and 3, and a chain on one register.
        issue(enc_i(12'd100, 5'd0, `F3_ADD_SUB, 5'd3));
        issue(enc_i(12'd1, 5'd3, `F3_ADD_SUB, 5'd4));
        issue(enc_i(12'd2, 5'd3, `F3_ADD_SUB, 5'd5));
        issue(enc_i(12'd3, 5'd3, `F3_ADD_SUB, 5'd6));
        issue(enc_r(`F7_BASE, 5'd5, 5'd4, `F3_ADD_SUB, 5'd1));
        issue(enc_r(`F7_ALT, 5'd6, 5'd1, `F3_ADD_SUB, 5'd2));
        issue(enc_r(`F7_BASE, 5'd2, 5'd1, `F3_ADD_SUB, 5'd1));
        repeat (3) begin
            issue(enc_i(12'd1, 5'd3, `F3_ADD_SUB, 5'd3));
        end
        issue(enc_r(`F7_BASE, 5'd3, 5'd3, `F3_ADD_SUB, 5'd7));

        // x0, an illegal opcode and idle gaps.
        issue(enc_i(12'd55, 5'd0, `F3_ADD_SUB, 5'd0));
        issue(enc_r(`F7_BASE, 5'd0, 5'd0, `F3_ADD_SUB, 5'd5));
        issue({12'h123, 5'd1, `F3_ADD_SUB, 5'd2, opc_illegal});
        issue(enc_r(`F7_BASE, 5'd0, 5'd2, `F3_ADD_SUB, 5'd6));
        idle(2);
        issue(enc_i(12'h05a, 5'd0, `F3_ADD_SUB, 5'd1));
        idle(1);
        issue(enc_i(12'hf81, 5'd1, `F3_XOR, 5'd1));
        idle(3);

        for (int n = 0; n < num_random; n++) begin
            issue_random();
        end
        idle(6);

        $display("Summary: %0d errors over %0d cycle checks and %0d register writes",
                 error_count, check_count, write_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: cpu.f
+incdir+include
rtl/rv_pkg.sv
rtl/pipe_reg.sv
rtl/fetch_stage.sv
rtl/reg_bank.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/writeback_stage.sv
rtl/cpu.sv
bench/cpu_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and search the log for the result.
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb -f cpu.f -o cpu_tb_sim \
    && ./obj_dir/cpu_tb_sim > sim.log 2>&1 \
    || echo "Verilator build or simulation run failed"

[ -f sim.log ] && cat sim.log

grep -q "TEST PASSED" sim.log 2>/dev/null \
    && echo "Simulation passed" && exit 0 \
    || { echo "Simulation failed"; exit 1; }
